// File: run_sim.sh
#!/bin/sh
# build and run the mac testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module mac_tb -f src.f -o mac_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mac_tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: src.f
verilog/mac_pkg.sv
verilog/mac_rx_stream_if.sv
verilog/mac_crc32.sv
verilog/mac_rx_path.sv
verilog/mac_tx_path.sv
verilog/mac_status_regs.sv
verilog/mac_top.sv
testbench/mac_properties.sv
testbench/mac_tb.sv

// File: testbench/mac_properties.sv
// concurrent checks on the rx stream, axi read channel and tx enable
// bound to mac_top, failures come out as assertion errors
`timescale 1ns/1ns
`default_nettype none

module mac_properties (
    input wire logic        mac_rx_clk,
    input wire logic        arst_n_i,
    input wire logic        rx_valid_o,
    input wire logic        rx_sof_o,
    input wire logic        rx_eof_o,
    input wire logic        rx_fr_good_o,
    input wire logic        rx_fr_err_o,
    input wire logic        s_axi_rvalid_o,
    input wire logic        s_axi_rready_i,
    input wire logic [31:0] s_axi_rdata_o,
    input wire logic        tx_en_o
);

    // markers only ride on a valid byte
    a_marker_valid: assert property (@(posedge mac_rx_clk) disable iff (!arst_n_i)
        (rx_sof_o || rx_eof_o) |-> rx_valid_o)
        else $error("sof or eof without valid");

    a_verdict_onehot: assert property (@(posedge mac_rx_clk) disable iff (!arst_n_i)
        !(rx_fr_good_o && rx_fr_err_o))
        else $error("fr_good and fr_err both high");

    a_rdata_hold: assert property (@(posedge mac_rx_clk) disable iff (!arst_n_i)
        (s_axi_rvalid_o && !s_axi_rready_i) |=> $stable(s_axi_rdata_o))
        else $error("rdata changed while waiting for rready");

    a_tx_quiet_in_reset: assert property (@(posedge mac_rx_clk)
        !arst_n_i |-> !tx_en_o)
        else $error("tx_en_o high during reset");

endmodule

bind mac_top mac_properties u_props (
    .mac_rx_clk     (mac_rx_clk),
    .arst_n_i       (arst_n_i),
    .rx_valid_o     (rx_valid_o),
    .rx_sof_o       (rx_sof_o),
    .rx_eof_o       (rx_eof_o),
    .rx_fr_good_o   (rx_fr_good_o),
    .rx_fr_err_o    (rx_fr_err_o),
    .s_axi_rvalid_o (s_axi_rvalid_o),
    .s_axi_rready_i (s_axi_rready_i),
    .s_axi_rdata_o  (s_axi_rdata_o),
    .tx_en_o        (tx_en_o)
);

`default_nettype wire

// File: testbench/mac_tb.sv
// testbench for the mac logic: tx frames looped back into the rx inputs
// frame table applied in a loop, then counters and status read over axi4-lite
`timescale 1ns/1ns
`default_nettype none

module mac_tb;

    localparam int n_tests = 5;
    localparam int max_wait = 50;   // cycles, for every handshake wait

    typedef logic [7:0] byte_q_t [$];

    logic                    mac_rx_clk;
    logic                    arst_n_i;
    logic [7:0]              rx_d_i;
    logic                    rx_dv_i;
    logic                    rx_er_i;
    logic [7:0]              rx_d_o;
    logic                    rx_valid_o;
    logic                    rx_sof_o;
    logic                    rx_eof_o;
    logic                    rx_fr_good_o;
    logic                    rx_fr_err_o;
    mac_pkg::inband_status_t status_o;
    logic [7:0]              tx_d_i;
    logic                    tx_valid_i;
    logic                    tx_sof_i;
    logic                    tx_eof_i;
    logic [7:0]              tx_d_o;
    logic                    tx_en_o;
    logic [3:0]              s_axi_awaddr_i;
    logic                    s_axi_awvalid_i;
    logic                    s_axi_awready_o;
    logic [31:0]             s_axi_wdata_i;
    logic                    s_axi_wvalid_i;
    logic                    s_axi_wready_o;
    logic [1:0]              s_axi_bresp_o;
    logic                    s_axi_bvalid_o;
    logic                    s_axi_bready_i;
    logic [3:0]              s_axi_araddr_i;
    logic                    s_axi_arvalid_i;
    logic                    s_axi_arready_o;
    logic [31:0]             s_axi_rdata_o;
    logic [1:0]              s_axi_rresp_o;
    logic                    s_axi_rvalid_o;
    logic                    s_axi_rready_i;

    integer seed;
    int     good_tally;
    int     bad_tally;

    // frame table: name, payload length, corrupt fcs, rx error, gap status
    string      t_name    [n_tests];
    int         t_len     [n_tests];
    logic       t_corrupt [n_tests];
    logic       t_err     [n_tests];
    logic [7:0] t_gap     [n_tests];

    mac_top dut_i (.*);

    always #2 mac_rx_clk = ~mac_rx_clk;  // 4 ns period

    // ------------------------------------------------------------------------
    // error reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "test stopped");
    endtask

    task automatic compare_byte(input string nm, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %h, actual %h", nm, exp, act));
    endtask

    task automatic compare_status(input string nm, input mac_pkg::inband_status_t exp,
                                  input mac_pkg::inband_status_t act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %h, actual %h", nm, exp, act));
    endtask

    task automatic compare_word(input string nm, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %h, actual %h", nm, exp, act));
    endtask

    task automatic compare_bit(input string nm, input logic exp, input logic act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %b, actual %b", nm, exp, act));
    endtask

    task automatic compare_resp(input string nm, input mac_pkg::axi_resp_t exp,
                                input mac_pkg::axi_resp_t act);
        if (act !== exp) abort_run($sformatf("Mismatch %s: expected %h, actual %h", nm, exp, act));
    endtask

    // reflected crc-32, lsb first, final inversion gives the fcs
    function automatic logic [31:0] ref_fcs(input byte_q_t data);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        foreach (data[k]) begin
            crc = crc ^ {24'h0, data[k]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    task automatic load_table();
        t_name[0] = "short_good"; t_len[0] = 8;  t_corrupt[0] = 0; t_err[0] = 0; t_gap[0] = 8'h0D;
        t_name[1] = "long_good";  t_len[1] = 46; t_corrupt[1] = 0; t_err[1] = 0; t_gap[1] = 8'h0B;
        t_name[2] = "bad_fcs";    t_len[2] = 20; t_corrupt[2] = 1; t_err[2] = 0; t_gap[2] = 8'h03;
        t_name[3] = "rx_error";   t_len[3] = 16; t_corrupt[3] = 0; t_err[3] = 1; t_gap[3] = 8'h00;
        t_name[4] = "one_byte";   t_len[4] = 1;  t_corrupt[4] = 0; t_err[4] = 0; t_gap[4] = 8'h05;
    endtask

    // ------------------------------------------------------------------------
    // one frame: tx drive, loopback, tx wire check and rx stream check
    // ------------------------------------------------------------------------
    task automatic run_frame(input int i);
        byte_q_t     payload;
        byte_q_t     rx_exp;
        logic [31:0] fcs;
        logic [7:0]  exp_tx;
        logic        exp_good;
        int          len;
        int          w;
        int          rx_cnt;
        string       nm;
        len = t_len[i];
        nm  = t_name[i];
        for (int k = 0; k < len; k++) payload.push_back(8'($random(seed)));
        fcs = ref_fcs(payload);
        rx_exp = payload;
        for (int k = 0; k < mac_pkg::fcs_len; k++) rx_exp.push_back(fcs[8*k +: 8]);
        if (t_corrupt[i]) rx_exp[len] = rx_exp[len] ^ 8'h01;  // first fcs byte
        exp_good = !t_corrupt[i] && !t_err[i];
        rx_cnt = 0;
        for (int c = 0; c < len + 32; c++) begin
            @(negedge mac_rx_clk);
            w = c - 1;  // wire slot shown after the last rising edge
            compare_bit({nm, " tx_en"}, (c >= 1 && c <= len + 12), tx_en_o);
            if (tx_en_o) begin
                if (w < 7) exp_tx = 8'h55;
                else if (w == 7) exp_tx = 8'hD5;
                else if (w < 8 + len) exp_tx = payload[w - 8];
                else exp_tx = fcs[8*(w - 8 - len) +: 8];
                compare_byte($sformatf("%s tx byte %0d", nm, w), exp_tx, tx_d_o);
            end
            if (rx_valid_o) begin
                if (rx_cnt >= rx_exp.size()) abort_run({nm, ": rx stream longer than frame"});
                compare_byte($sformatf("%s rx byte %0d", nm, rx_cnt), rx_exp[rx_cnt], rx_d_o);
                compare_bit({nm, " rx sof"}, rx_cnt == 0, rx_sof_o);
                compare_bit({nm, " rx eof"}, rx_cnt == rx_exp.size() - 1, rx_eof_o);
                if (rx_eof_o) begin
                    compare_bit({nm, " fr_good"}, exp_good, rx_fr_good_o);
                    compare_bit({nm, " fr_err"}, !exp_good, rx_fr_err_o);
                end
                rx_cnt++;
            end
            // tx input for this cycle
            tx_valid_i = (c < len);
            tx_sof_i   = (c == 0);
            tx_eof_i   = (c == len - 1);
            tx_d_i     = 8'h00;
            if (c < len) tx_d_i = payload[c];
            // loopback, gap carries the status byte
            rx_dv_i = tx_en_o;
            rx_d_i  = tx_en_o ? tx_d_o : t_gap[i];
            if (t_corrupt[i] && w == 8 + len) rx_d_i = tx_d_o ^ 8'h01;
            rx_er_i = t_err[i] && (w == 8 + len / 2);
        end
        compare_word({nm, " rx byte count"}, rx_exp.size(), rx_cnt);
        compare_status({nm, " gap status"}, mac_pkg::inband_status_t'(t_gap[i]), status_o);
        if (exp_good) good_tally++;
        else bad_tally++;
    endtask

    // ------------------------------------------------------------------------
    // axi4-lite master tasks
    // ------------------------------------------------------------------------
    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output mac_pkg::axi_resp_t resp);
        int n;
        n = 0;
        while (!s_axi_arready_o) begin
            if (++n > max_wait) abort_run("timeout waiting for arready");
            @(negedge mac_rx_clk);
        end
        s_axi_araddr_i  = addr;
        s_axi_arvalid_i = 1'b1;
        s_axi_rready_i  = 1'b0;
        @(negedge mac_rx_clk);  // accepted on the edge just passed
        s_axi_arvalid_i = 1'b0;
        n = 0;
        while (!s_axi_rvalid_o) begin
            if (++n > max_wait) abort_run("timeout waiting for rvalid");
            @(negedge mac_rx_clk);
        end
        @(negedge mac_rx_clk);  // one stalled cycle, response must hold
        compare_bit("rvalid held without rready", 1'b1, s_axi_rvalid_o);
        data = s_axi_rdata_o;
        resp = mac_pkg::axi_resp_t'(s_axi_rresp_o);
        s_axi_rready_i = 1'b1;
        @(negedge mac_rx_clk);
        s_axi_rready_i = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output mac_pkg::axi_resp_t resp);
        int n;
        n = 0;
        while (s_axi_bvalid_o) begin
            if (++n > max_wait) abort_run("timeout waiting for write response to clear");
            @(negedge mac_rx_clk);
        end
        s_axi_awaddr_i  = addr;
        s_axi_wdata_i   = data;
        s_axi_awvalid_i = 1'b1;
        s_axi_wvalid_i  = 1'b1;
        s_axi_bready_i  = 1'b1;
        #1;  // mid half-cycle, before the accepting edge
        compare_bit("write awready", 1'b1, s_axi_awready_o);
        compare_bit("write wready", 1'b1, s_axi_wready_o);
        @(negedge mac_rx_clk);
        s_axi_awvalid_i = 1'b0;
        s_axi_wvalid_i  = 1'b0;
        n = 0;
        while (!s_axi_bvalid_o) begin
            if (++n > max_wait) abort_run("timeout waiting for bvalid");
            @(negedge mac_rx_clk);
        end
        resp = mac_pkg::axi_resp_t'(s_axi_bresp_o);
        @(negedge mac_rx_clk);
        s_axi_bready_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0]        rd;
        mac_pkg::axi_resp_t resp;
        seed            = 32'h876391d7;
        good_tally      = 0;
        bad_tally       = 0;
        mac_rx_clk      = 1'b0;
        arst_n_i        = 1'b0;
        rx_d_i          = 8'h00;
        rx_dv_i         = 1'b0;
        rx_er_i         = 1'b0;
        tx_d_i          = 8'h00;
        tx_valid_i      = 1'b0;
        tx_sof_i        = 1'b0;
        tx_eof_i        = 1'b0;
        s_axi_awaddr_i  = 4'h0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i   = 32'h0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_bready_i  = 1'b0;
        s_axi_araddr_i  = 4'h0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b0;
        load_table();
        repeat (10) @(posedge mac_rx_clk);
        @(negedge mac_rx_clk);
        arst_n_i = 1'b1;

        for (int i = 0; i < n_tests; i++) run_frame(i);

        axi_read(mac_pkg::reg_status_addr, rd, resp);
        compare_word("status reg", {24'h0, t_gap[n_tests - 1]}, rd);
        compare_resp("status resp", mac_pkg::resp_okay, resp);
        axi_read(mac_pkg::reg_good_addr, rd, resp);
        compare_word("good count", good_tally, rd);
        axi_read(mac_pkg::reg_bad_addr, rd, resp);
        compare_word("bad count", bad_tally, rd);
        axi_read(4'h2, rd, resp);  // unmapped
        compare_resp("unmapped resp", mac_pkg::resp_slverr, resp);
        compare_word("unmapped data", 32'h0, rd);
        axi_write(mac_pkg::reg_ctrl_addr, 32'h1, resp);
        compare_resp("ctrl write resp", mac_pkg::resp_okay, resp);
        axi_read(mac_pkg::reg_good_addr, rd, resp);
        compare_word("good count cleared", 32'h0, rd);
        axi_read(mac_pkg::reg_bad_addr, rd, resp);
        compare_word("bad count cleared", 32'h0, rd);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/mac_crc32.sv
// ethernet crc-32 register, one byte per enabled cycle
// shared by the rx fcs check and the tx fcs generator
`timescale 1ns/1ns
`default_nettype none

module mac_crc32 (
    input  logic        mac_rx_clk,
    input  logic        arst_n_i,
    input  logic        clear_i,    // load init value, wins over enable
    input  logic        enable_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    logic [31:0] crc_next;

    // data bits enter lsb first as on the wire
    // register kept msb first, so the fcs is its inverted bit reverse
    always_comb begin
        crc_next = crc_o;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[31] ^ data_i[i]) begin
                crc_next = {crc_next[30:0], 1'b0} ^ 32'h04C1_1DB7;  // 802.3 poly
            end else begin
                crc_next = {crc_next[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crc_o <= mac_pkg::crc_init;
        end else if (clear_i) begin
            crc_o <= mac_pkg::crc_init;
        end else if (enable_i) begin
            crc_o <= crc_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mac_pkg.sv
// shared constants, register map and types of the rgmii mac logic
// modules refer to these by scoped name, the package is never imported
`default_nettype none

package mac_pkg;

    // -------------------------------------------------------------------------
    // frame bytes and crc
    // -------------------------------------------------------------------------
    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hD5;
    localparam int          preamble_len  = 7;             // bytes before the sfd
    localparam logic [31:0] crc_init      = 32'hFFFF_FFFF;
    localparam logic [31:0] crc_residue   = 32'hC704_DD7B; // good frame incl. fcs
    localparam int          fcs_len       = 4;

    // pipeline depths, input byte to output byte
    localparam int rx_latency = 2;
    localparam int tx_latency = 9;

    // -------------------------------------------------------------------------
    // axi4-lite register map, byte addresses
    // -------------------------------------------------------------------------
    localparam logic [3:0] reg_status_addr = 4'h0;
    localparam logic [3:0] reg_good_addr   = 4'h4;
    localparam logic [3:0] reg_bad_addr    = 4'h8;
    localparam logic [3:0] reg_ctrl_addr   = 4'hC;

    // in-band phy status, sent by the phy during the interframe gap
    typedef struct packed {
        logic [3:0] reserved;
        logic       full_duplex;
        logic [1:0] speed;        // 0 = 10M  1 = 100M  2 = 1G
        logic       link_up;
    } inband_status_t;

    // one rx byte, frame data or gap status
    typedef union packed {
        logic [7:0]     data;
        inband_status_t status;
    } rx_byte_u;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

endpackage

`default_nettype wire

// File: verilog/mac_rx_path.sv
// receive side: strips preamble and sfd, checks the fcs by crc residue,
// marks the frame and keeps the in-band phy status seen in the gap
`timescale 1ns/1ns
`default_nettype none

module mac_rx_path (
    input  logic                    mac_rx_clk,
    input  logic                    arst_n_i,
    input  logic [7:0]              rx_d_i,
    input  logic                    rx_dv_i,
    input  logic                    rx_er_i,
    mac_rx_stream_if.producer       strm,
    output mac_pkg::inband_status_t status_o
);

    typedef enum logic [1:0] {
        st_idle,    // gap, waiting for preamble
        st_pre,     // preamble seen, waiting for sfd
        st_frame
    } rx_state_t;

    mac_pkg::rx_byte_u in_byte;
    logic [7:0]        d_pipe [mac_pkg::rx_latency];
    logic              dv0;
    logic              er0;
    rx_state_t         state;
    logic              first_q;     // next frame byte carries sof
    logic              err_seen;
    logic              sfd_hit;
    logic              in_frame;
    logic              v1;
    logic              sof1;
    logic              eof1;
    logic              crc_ok;
    logic [31:0]       crc;

    assign in_byte.data = rx_d_i;

    // stage 0 drives the fsm and crc
    assign sfd_hit  = (state == st_pre) && dv0 && (d_pipe[0] == mac_pkg::sfd_byte);
    assign in_frame = (state == st_frame) && dv0;

    always_ff @(posedge mac_rx_clk) begin
        d_pipe[0] <= in_byte.data;
        for (int i = 1; i < mac_pkg::rx_latency; i++) begin
            d_pipe[i] <= d_pipe[i - 1];
        end
    end

    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dv0      <= 1'b0;
            er0      <= 1'b0;
            state    <= st_idle;
            first_q  <= 1'b0;
            err_seen <= 1'b0;
            v1       <= 1'b0;
            sof1     <= 1'b0;
            eof1     <= 1'b0;
            status_o <= '0;
        end else begin
            dv0 <= rx_dv_i;
            er0 <= rx_er_i;
            case (state)
                st_idle: begin
                    if (dv0 && d_pipe[0] == mac_pkg::preamble_byte) state <= st_pre;
                end
                st_pre: begin
                    if (sfd_hit) begin
                        state <= st_frame;
                    end else if (!dv0 || d_pipe[0] != mac_pkg::preamble_byte) begin
                        state <= st_idle;  // broken preamble
                    end
                end
                default: begin
                    if (!dv0) state <= st_idle;
                end
            endcase

            if (sfd_hit) begin
                first_q  <= 1'b1;
                err_seen <= 1'b0;
            end else if (in_frame) begin
                first_q  <= 1'b0;
                err_seen <= err_seen | er0;
            end

            // stage 1, eof when dv drops behind the byte
            v1   <= in_frame;
            sof1 <= in_frame & first_q;
            eof1 <= in_frame & ~rx_dv_i;

            // gap byte read as phy status
            if (!rx_dv_i && !rx_er_i) status_o <= in_byte.status;
        end
    end

    mac_crc32 u_crc (
        .mac_rx_clk (mac_rx_clk),
        .arst_n_i   (arst_n_i),
        .clear_i    (sfd_hit),
        .enable_i   (in_frame),
        .data_i     (d_pipe[0]),
        .crc_o      (crc)
    );

    assign crc_ok = (crc == mac_pkg::crc_residue) && !err_seen;

    assign strm.data    = d_pipe[mac_pkg::rx_latency - 1];
    assign strm.valid   = v1;
    assign strm.sof     = sof1;
    assign strm.eof     = eof1;
    assign strm.fr_good = eof1 & crc_ok;
    assign strm.fr_err  = eof1 & ~crc_ok;

endmodule

`default_nettype wire

// File: verilog/mac_rx_stream_if.sv
// receive frame stream between the rx path and its consumers
// one byte per cycle while valid, verdict only in the eof cycle
`timescale 1ns/1ns
`default_nettype none

interface mac_rx_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       sof;      // first byte after the sfd
    logic       eof;      // last fcs byte
    logic       fr_good;
    logic       fr_err;

    // rx path side
    modport producer (
        output data, valid, sof, eof, fr_good, fr_err
    );

    // observers, no back-pressure
    modport monitor (
        input data, valid, sof, eof, fr_good, fr_err
    );

endinterface

`default_nettype wire

// File: verilog/mac_status_regs.sv
// axi4-lite slave with the phy status and good / bad frame counters
// writing 1 to ctrl bit 0 clears both counters
`timescale 1ns/1ns
`default_nettype none

module mac_status_regs (
    input  logic                    mac_rx_clk,
    input  logic                    arst_n_i,
    mac_rx_stream_if.monitor        mon,
    input  mac_pkg::inband_status_t status_i,
    input  logic [3:0]              s_axi_awaddr_i,
    input  logic                    s_axi_awvalid_i,
    output logic                    s_axi_awready_o,
    input  logic [31:0]             s_axi_wdata_i,
    input  logic                    s_axi_wvalid_i,
    output logic                    s_axi_wready_o,
    output mac_pkg::axi_resp_t      s_axi_bresp_o,
    output logic                    s_axi_bvalid_o,
    input  logic                    s_axi_bready_i,
    input  logic [3:0]              s_axi_araddr_i,
    input  logic                    s_axi_arvalid_i,
    output logic                    s_axi_arready_o,
    output logic [31:0]             s_axi_rdata_o,
    output mac_pkg::axi_resp_t      s_axi_rresp_o,
    output logic                    s_axi_rvalid_o,
    input  logic                    s_axi_rready_i
);

    logic [15:0]        good_cnt;
    logic [15:0]        bad_cnt;
    logic               wr_acc;
    logic               rd_acc;
    logic               cnt_clr;
    logic [31:0]        rd_data;
    mac_pkg::axi_resp_t rd_resp;
    mac_pkg::axi_resp_t wr_resp;

    // -------------------------------------------------------------------------
    // handshakes, one outstanding read and one outstanding write
    // -------------------------------------------------------------------------
    assign wr_acc          = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
    assign s_axi_awready_o = wr_acc;
    assign s_axi_wready_o  = wr_acc;
    assign s_axi_arready_o = !s_axi_rvalid_o;
    assign rd_acc          = s_axi_arvalid_i && s_axi_arready_o;
    assign cnt_clr = wr_acc && (s_axi_awaddr_i == mac_pkg::reg_ctrl_addr) && s_axi_wdata_i[0];

    // read mux
    always_comb begin
        rd_data = '0;
        rd_resp = mac_pkg::resp_okay;
        case (s_axi_araddr_i)
            mac_pkg::reg_status_addr: rd_data = {24'h0, status_i};
            mac_pkg::reg_good_addr:   rd_data = {16'h0, good_cnt};
            mac_pkg::reg_bad_addr:    rd_data = {16'h0, bad_cnt};
            mac_pkg::reg_ctrl_addr:   rd_data = '0;  // clear bit reads back 0
            default:                  rd_resp = mac_pkg::resp_slverr;
        endcase
    end

    // writes only act on ctrl, the rest is read-only
    always_comb begin
        case (s_axi_awaddr_i)
            mac_pkg::reg_status_addr,
            mac_pkg::reg_good_addr,
            mac_pkg::reg_bad_addr,
            mac_pkg::reg_ctrl_addr: wr_resp = mac_pkg::resp_okay;
            default:                wr_resp = mac_pkg::resp_slverr;
        endcase
    end

    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_axi_rvalid_o <= 1'b0;
            s_axi_bvalid_o <= 1'b0;
            good_cnt       <= '0;
            bad_cnt        <= '0;
        end else begin
            if (rd_acc) begin
                s_axi_rvalid_o <= 1'b1;
            end else if (s_axi_rready_i) begin
                s_axi_rvalid_o <= 1'b0;
            end
            if (wr_acc) begin
                s_axi_bvalid_o <= 1'b1;
            end else if (s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end

            // saturating frame counters
            if (cnt_clr) begin
                good_cnt <= '0;
                bad_cnt  <= '0;
            end else begin
                if (mon.eof && mon.fr_good && !(&good_cnt)) good_cnt <= good_cnt + 16'd1;
                if (mon.eof && mon.fr_err && !(&bad_cnt)) bad_cnt <= bad_cnt + 16'd1;
            end
        end
    end

    // response payload, held until the handshake
    always_ff @(posedge mac_rx_clk) begin
        if (rd_acc) begin
            s_axi_rdata_o <= rd_data;
            s_axi_rresp_o <= rd_resp;
        end
        if (wr_acc) s_axi_bresp_o <= wr_resp;
    end

endmodule

`default_nettype wire

// File: verilog/mac_top.sv
// top level of the rgmii mac logic, byte streams on mac_rx_clk
// rx path, tx path and the axi4-lite status block on plain ports
`timescale 1ns/1ns
`default_nettype none

module mac_top (
    input  logic                    mac_rx_clk,
    input  logic                    arst_n_i,
    // receive byte stream from the ddr capture
    input  logic [7:0]              rx_d_i,
    input  logic                    rx_dv_i,
    input  logic                    rx_er_i,
    output logic [7:0]              rx_d_o,
    output logic                    rx_valid_o,
    output logic                    rx_sof_o,
    output logic                    rx_eof_o,
    output logic                    rx_fr_good_o,
    output logic                    rx_fr_err_o,
    output mac_pkg::inband_status_t status_o,
    // transmit stream
    input  logic [7:0]              tx_d_i,
    input  logic                    tx_valid_i,
    input  logic                    tx_sof_i,
    input  logic                    tx_eof_i,
    output logic [7:0]              tx_d_o,
    output logic                    tx_en_o,
    // axi4-lite slave
    input  logic [3:0]              s_axi_awaddr_i,
    input  logic                    s_axi_awvalid_i,
    output logic                    s_axi_awready_o,
    input  logic [31:0]             s_axi_wdata_i,
    input  logic                    s_axi_wvalid_i,
    output logic                    s_axi_wready_o,
    output logic [1:0]              s_axi_bresp_o,
    output logic                    s_axi_bvalid_o,
    input  logic                    s_axi_bready_i,
    input  logic [3:0]              s_axi_araddr_i,
    input  logic                    s_axi_arvalid_i,
    output logic                    s_axi_arready_o,
    output logic [31:0]             s_axi_rdata_o,
    output logic [1:0]              s_axi_rresp_o,
    output logic                    s_axi_rvalid_o,
    input  logic                    s_axi_rready_i
);

    mac_rx_stream_if rx_strm ();

    mac_rx_path u_rx (
        .mac_rx_clk (mac_rx_clk),
        .arst_n_i   (arst_n_i),
        .rx_d_i     (rx_d_i),
        .rx_dv_i    (rx_dv_i),
        .rx_er_i    (rx_er_i),
        .strm       (rx_strm),
        .status_o   (status_o)
    );

    // stream out to the user side
    assign rx_d_o       = rx_strm.data;
    assign rx_valid_o   = rx_strm.valid;
    assign rx_sof_o     = rx_strm.sof;
    assign rx_eof_o     = rx_strm.eof;
    assign rx_fr_good_o = rx_strm.fr_good;
    assign rx_fr_err_o  = rx_strm.fr_err;

    mac_tx_path u_tx (
        .mac_rx_clk (mac_rx_clk),
        .arst_n_i   (arst_n_i),
        .tx_d_i     (tx_d_i),
        .tx_valid_i (tx_valid_i),
        .tx_sof_i   (tx_sof_i),
        .tx_eof_i   (tx_eof_i),
        .tx_d_o     (tx_d_o),
        .tx_en_o    (tx_en_o)
    );

    mac_status_regs u_regs (
        .mac_rx_clk      (mac_rx_clk),
        .arst_n_i        (arst_n_i),
        .mon             (rx_strm),
        .status_i        (status_o),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i)
    );

endmodule

`default_nettype wire

// File: verilog/mac_tx_path.sv
// transmit side: delays the payload, puts preamble and sfd in front
// and appends the fcs, lsb byte first
`timescale 1ns/1ns
`default_nettype none

module mac_tx_path (
    input  logic       mac_rx_clk,
    input  logic       arst_n_i,
    input  logic [7:0] tx_d_i,
    input  logic       tx_valid_i,
    input  logic       tx_sof_i,
    input  logic       tx_eof_i,
    output logic [7:0] tx_d_o,
    output logic       tx_en_o
);

    logic [7:0]                                        dly [mac_pkg::tx_latency];
    logic [mac_pkg::preamble_len:0]                    pre_sr;  // preamble + sfd slots
    logic [mac_pkg::tx_latency+mac_pkg::fcs_len-1:0]   fcs_sr;  // low bit marks fcs slot
    logic [31:0]                                       crc;
    logic [31:0]                                       fcs_next;
    logic [31:0]                                       fcs_q;
    logic                                              fcs_last;

    mac_crc32 u_crc (
        .mac_rx_clk (mac_rx_clk),
        .arst_n_i   (arst_n_i),
        .clear_i    (~tx_valid_i),   // idles at init between frames
        .enable_i   (tx_valid_i),
        .data_i     (tx_d_i),
        .crc_o      (crc)
    );

    // inverted and bit reversed crc
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            fcs_next[i] = ~crc[31 - i];
        end
    end

    assign fcs_last = fcs_sr[mac_pkg::tx_latency + mac_pkg::fcs_len - 1]
                    & ~fcs_sr[mac_pkg::tx_latency + mac_pkg::fcs_len - 2];

    always_ff @(posedge mac_rx_clk) begin
        dly[0] <= tx_valid_i ? tx_d_i : 8'h00;
        for (int i = 1; i < mac_pkg::tx_latency; i++) begin
            dly[i] <= dly[i - 1];
        end
        if (fcs_sr[0]) fcs_q <= fcs_next;  // crc complete one cycle after eof
    end

    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pre_sr  <= '0;
            fcs_sr  <= '0;
            tx_en_o <= 1'b0;
        end else begin
            pre_sr <= tx_sof_i ? '1 : {pre_sr[mac_pkg::preamble_len-1:0], 1'b0};
            fcs_sr <= tx_eof_i ? '1 : {fcs_sr[$high(fcs_sr)-1:0], 1'b0};
            if (tx_sof_i) begin
                tx_en_o <= 1'b1;
            end else if (fcs_last) begin
                tx_en_o <= 1'b0;
            end
        end
    end

    // output byte select, preamble and sfd first
    always_comb begin
        tx_d_o = dly[mac_pkg::tx_latency - 1];
        for (int i = 0; i < mac_pkg::fcs_len; i++) begin
            if (fcs_sr[mac_pkg::tx_latency + i] && !fcs_sr[mac_pkg::tx_latency + i - 1]) begin
                tx_d_o = fcs_q[8*i +: 8];
            end
        end
        if (pre_sr == {1'b1, {mac_pkg::preamble_len{1'b0}}}) begin
            tx_d_o = mac_pkg::sfd_byte;
        end else if (|pre_sr[mac_pkg::preamble_len-1:0]) begin
            tx_d_o = mac_pkg::preamble_byte;
        end
        if (!tx_en_o) tx_d_o = 8'h00;  // quiet bus between frames
    end

endmodule

`default_nettype wire
